/* ctrlPkg.sv */
// Codes follow the reference MIPS subset; opcodes or functs not listed here decode as illegal
package ctrlPkg;

    localparam int opWidth = 6;
    localparam int functWidth = 6;
    localparam int stepWidth = 3;

    // Opcodes
    localparam logic [opWidth-1:0] opTypeR = 6'b000000;
    localparam logic [opWidth-1:0] opAddi = 6'b001000;
    localparam logic [opWidth-1:0] opSram = 6'b000001;
    localparam logic [opWidth-1:0] opSb = 6'b101000;
    localparam logic [opWidth-1:0] opSh = 6'b101001;
    localparam logic [opWidth-1:0] opSw = 6'b101011;

    // R-type funct codes
    localparam logic [functWidth-1:0] functAdd = 6'b100000;
    localparam logic [functWidth-1:0] functSub = 6'b100010;
    localparam logic [functWidth-1:0] functSll = 6'b000000;
    localparam logic [functWidth-1:0] functSllv = 6'b000100;
    localparam logic [functWidth-1:0] functSra = 6'b000011;
    localparam logic [functWidth-1:0] functSrav = 6'b000111;
    localparam logic [functWidth-1:0] functSrl = 6'b000010;

    typedef enum logic [2:0] {
        clsArith,
        clsShift,
        clsStore,
        clsShiftMem,
        clsIllegal
    } instrClass;

    typedef enum logic [2:0] {
        aluNone = 3'd0,
        aluAdd = 3'd1,
        aluSub = 3'd2
    } aluOpT;

    typedef enum logic [2:0] {
        shIdle = 3'd0,
        shLoad = 3'd1,
        shLeft = 3'd2,
        shRightLogic = 3'd3,
        shRightArith = 3'd4
    } shiftKindT;

    typedef enum logic [1:0] {
        stWord = 2'd0,
        stHalf = 2'd1,
        stByte = 2'd2
    } storeSizeT;

    typedef enum logic [2:0] {
        phInit,
        phFetch,
        phDecode,
        phExec,
        phOverflow,
        phIllegal
    } phaseT;

    // Phase lengths in cycles
    localparam logic [stepWidth-1:0] fetchSteps = 3'd4;
    localparam logic [stepWidth-1:0] decodeSteps = 3'd2;
    localparam logic [stepWidth-1:0] arithSteps = 3'd2;
    localparam logic [stepWidth-1:0] shiftSteps = 3'd3;
    localparam logic [stepWidth-1:0] storeSteps = 3'd5;
    localparam logic [stepWidth-1:0] shiftMemSteps = 3'd7;

    // Register file destination and write data
    localparam logic [1:0] wrRt = 2'd0;
    localparam logic [1:0] wrRd = 2'd1;
    localparam logic [1:0] wrSp = 2'd3;
    localparam logic [2:0] wdAlu = 3'd0;
    localparam logic [2:0] wdShift = 3'd5;
    localparam logic [2:0] wdSpInit = 3'd6;

    // Memory address and ALU operand muxes
    localparam logic [1:0] iorPc = 2'd0;
    localparam logic [1:0] iorAddr = 2'd3;
    localparam logic [1:0] srcAPc = 2'd0;
    localparam logic [1:0] srcARegA = 2'd2;
    localparam logic [1:0] srcBRegB = 2'd0;
    localparam logic [1:0] srcBFour = 2'd1;
    localparam logic [1:0] srcBImm = 2'd2;
    localparam logic [1:0] srcBBranch = 2'd3;

    // Shifter value and amount muxes
    localparam logic [1:0] shInRegA = 2'd0;
    localparam logic [1:0] shInRegB = 2'd2;
    localparam logic [1:0] shAmtReg = 2'd0;
    localparam logic [1:0] shAmtField = 2'd1;
    localparam logic [1:0] shAmtMem = 2'd2;

endpackage

/* decodeIf.sv */
// Fields change only in the cycle after a latch and hold until the next one
`timescale 1ns/1ps

interface decodeIf;

    ctrlPkg::instrClass cls;
    ctrlPkg::aluOpT aluOp;
    ctrlPkg::shiftKindT shiftKind;
    // Shift amount taken from a register instead of the shamt field
    logic shiftByReg;
    logic immOperand;
    ctrlPkg::storeSizeT storeSize;
    logic destIsRd;

    modport producer (
        output cls, aluOp, shiftKind, shiftByReg, immOperand, storeSize, destIsRd
    );

    modport consumer (
        input cls, aluOp, shiftKind, shiftByReg, immOperand, storeSize, destIsRd
    );

endinterface

/* opDecoder.sv */
// opcode and funct must be stable on the cycle latchInstr is high; unknown codes become illegal
`timescale 1ns/1ps

module opDecoder (
    input logic clk,
    input logic reset,
    input logic [ctrlPkg::opWidth-1:0] opcode,
    input logic [ctrlPkg::functWidth-1:0] funct,
    input logic latchInstr,
    decodeIf.producer dec
);

    ctrlPkg::instrClass clsNext;
    ctrlPkg::aluOpT aluNext;
    ctrlPkg::shiftKindT shiftNext;
    logic byRegNext;
    logic immNext;
    ctrlPkg::storeSizeT sizeNext;
    logic rdNext;

    always_comb begin
        clsNext = ctrlPkg::clsIllegal;
        aluNext = ctrlPkg::aluNone;
        shiftNext = ctrlPkg::shIdle;
        byRegNext = 1'b0;
        immNext = 1'b0;
        sizeNext = ctrlPkg::stWord;
        rdNext = 1'b0;
        case (opcode)
            ctrlPkg::opTypeR: begin
                rdNext = 1'b1;
                case (funct)
                    ctrlPkg::functAdd: begin
                        clsNext = ctrlPkg::clsArith;
                        aluNext = ctrlPkg::aluAdd;
                    end
                    ctrlPkg::functSub: begin
                        clsNext = ctrlPkg::clsArith;
                        aluNext = ctrlPkg::aluSub;
                    end
                    ctrlPkg::functSll, ctrlPkg::functSllv: begin
                        clsNext = ctrlPkg::clsShift;
                        shiftNext = ctrlPkg::shLeft;
                        byRegNext = (funct == ctrlPkg::functSllv);
                    end
                    ctrlPkg::functSra, ctrlPkg::functSrav: begin
                        clsNext = ctrlPkg::clsShift;
                        shiftNext = ctrlPkg::shRightArith;
                        byRegNext = (funct == ctrlPkg::functSrav);
                    end
                    ctrlPkg::functSrl: begin
                        clsNext = ctrlPkg::clsShift;
                        shiftNext = ctrlPkg::shRightLogic;
                    end
                    default: begin
                        clsNext = ctrlPkg::clsIllegal;
                    end
                endcase
            end
            ctrlPkg::opAddi: begin
                clsNext = ctrlPkg::clsArith;
                aluNext = ctrlPkg::aluAdd;
                immNext = 1'b1;
            end
            ctrlPkg::opSram: begin
                // Address add first, then arithmetic shift of the loaded word
                clsNext = ctrlPkg::clsShiftMem;
                aluNext = ctrlPkg::aluAdd;
                shiftNext = ctrlPkg::shRightArith;
                immNext = 1'b1;
            end
            ctrlPkg::opSb, ctrlPkg::opSh, ctrlPkg::opSw: begin
                clsNext = ctrlPkg::clsStore;
                aluNext = ctrlPkg::aluAdd;
                immNext = 1'b1;
                if (opcode == ctrlPkg::opSb) begin
                    sizeNext = ctrlPkg::stByte;
                end else if (opcode == ctrlPkg::opSh) begin
                    sizeNext = ctrlPkg::stHalf;
                end
            end
            default: begin
                clsNext = ctrlPkg::clsIllegal;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dec.cls <= ctrlPkg::clsIllegal;
            dec.aluOp <= ctrlPkg::aluNone;
            dec.shiftKind <= ctrlPkg::shIdle;
            dec.shiftByReg <= 1'b0;
            dec.immOperand <= 1'b0;
            dec.storeSize <= ctrlPkg::stWord;
            dec.destIsRd <= 1'b0;
        end else if (latchInstr) begin
            dec.cls <= clsNext;
            dec.aluOp <= aluNext;
            dec.shiftKind <= shiftNext;
            dec.shiftByReg <= byRegNext;
            dec.immOperand <= immNext;
            dec.storeSize <= sizeNext;
            dec.destIsRd <= rdNext;
        end
    end

endmodule

/* stepSequencer.sv */
// overflow is only looked at on the last arithmetic execute step; no stall or handshake exists
`timescale 1ns/1ps

module stepSequencer (
    input logic clk,
    input logic reset,
    input logic overflow,
    decodeIf.consumer dec,
    output ctrlPkg::phaseT phase,
    output logic [ctrlPkg::stepWidth-1:0] step,
    output logic latchInstr
);

    ctrlPkg::phaseT phaseQ;
    ctrlPkg::phaseT nextPhase;
    logic [ctrlPkg::stepWidth-1:0] phaseLen;
    logic lastStep;

    // Class is only known after decode, so an illegal execute shows as the illegal phase
    assign phase = (phaseQ == ctrlPkg::phExec && dec.cls == ctrlPkg::clsIllegal) ?
        ctrlPkg::phIllegal : phaseQ;

    always_comb begin
        case (phase)
            ctrlPkg::phFetch: phaseLen = ctrlPkg::fetchSteps;
            ctrlPkg::phDecode: phaseLen = ctrlPkg::decodeSteps;
            ctrlPkg::phExec: begin
                case (dec.cls)
                    ctrlPkg::clsArith: phaseLen = ctrlPkg::arithSteps;
                    ctrlPkg::clsShift: phaseLen = ctrlPkg::shiftSteps;
                    ctrlPkg::clsStore: phaseLen = ctrlPkg::storeSteps;
                    ctrlPkg::clsShiftMem: phaseLen = ctrlPkg::shiftMemSteps;
                    default: phaseLen = 3'd1;
                endcase
            end
            default: phaseLen = 3'd1;
        endcase
    end

    assign lastStep = (step == phaseLen - 3'd1);
    assign latchInstr = (phase == ctrlPkg::phDecode) && lastStep;

    always_comb begin
        nextPhase = phaseQ;
        if (lastStep) begin
            case (phase)
                ctrlPkg::phInit: nextPhase = ctrlPkg::phFetch;
                ctrlPkg::phFetch: nextPhase = ctrlPkg::phDecode;
                ctrlPkg::phDecode: nextPhase = ctrlPkg::phExec;
                ctrlPkg::phExec: begin
                    if (dec.cls == ctrlPkg::clsArith && overflow) begin
                        nextPhase = ctrlPkg::phOverflow;
                    end else begin
                        nextPhase = ctrlPkg::phFetch;
                    end
                end
                default: nextPhase = ctrlPkg::phFetch;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            phaseQ <= ctrlPkg::phInit;
            step <= '0;
        end else begin
            phaseQ <= nextPhase;
            step <= lastStep ? '0 : step + 3'd1;
        end
    end

    stepInRange: assert property (
        @(posedge clk) disable iff (reset)
        step < phaseLen
    );

    // An overflow detour is the only way out of execute that skips straight fetch
    execExitsToFetch: assert property (
        @(posedge clk) disable iff (reset)
        (phase == ctrlPkg::phExec) ##1 (phase != ctrlPkg::phExec) |->
            (phase == ctrlPkg::phFetch) or
            ((phase == ctrlPkg::phOverflow) ##1 (phase == ctrlPkg::phFetch))
    );

endmodule

/* controlWordGen.sv */
// Outputs lag the sequencer by one cycle; a write that overflowed is dropped in the overflow phase
`timescale 1ns/1ps

module controlWordGen (
    input logic clk,
    input logic reset,
    input ctrlPkg::phaseT phase,
    input logic [ctrlPkg::stepWidth-1:0] step,
    decodeIf.consumer dec,
    output logic [1:0] iorD,
    output logic [1:0] wrReg,
    output logic [1:0] aluSrcA,
    output logic [1:0] aluSrcB,
    output logic [1:0] shiftIn,
    output logic [1:0] shiftSrc,
    output logic [2:0] wdReg,
    output logic pcWrite,
    output logic loadAB,
    output logic aluOutLoad,
    output logic memWrite,
    output logic memRead,
    output logic irWrite,
    output logic regWrite,
    output ctrlPkg::aluOpT aluOp,
    output ctrlPkg::shiftKindT shiftCtrl,
    output ctrlPkg::storeSizeT storeCtrl
);

    typedef struct packed {
        logic [1:0] iorD;
        logic [1:0] wrReg;
        logic [1:0] aluSrcA;
        logic [1:0] aluSrcB;
        logic [1:0] shiftIn;
        logic [1:0] shiftSrc;
        logic [2:0] wdReg;
        logic pcWrite;
        logic loadAB;
        logic aluOutLoad;
        logic memWrite;
        logic memRead;
        logic irWrite;
        logic regWrite;
        ctrlPkg::aluOpT aluOp;
        ctrlPkg::shiftKindT shiftCtrl;
        ctrlPkg::storeSizeT storeCtrl;
    } ctrlWordT;

    ctrlWordT word;
    ctrlWordT wordQ;

    always_comb begin
        word = '0;
        case (phase)
            ctrlPkg::phInit: begin
                // Stack pointer initial value
                word.regWrite = 1'b1;
                word.wrReg = ctrlPkg::wrSp;
                word.wdReg = ctrlPkg::wdSpInit;
            end
            ctrlPkg::phFetch: begin
                if (step == 3'd3) begin
                    word.pcWrite = 1'b1;
                    word.irWrite = 1'b1;
                end else begin
                    word.memRead = 1'b1;
                    word.iorD = ctrlPkg::iorPc;
                    word.aluSrcA = ctrlPkg::srcAPc;
                    word.aluSrcB = ctrlPkg::srcBFour;
                    word.aluOp = ctrlPkg::aluAdd;
                end
            end
            ctrlPkg::phDecode: begin
                if (step == 3'd0) begin
                    // Speculative branch target
                    word.aluSrcA = ctrlPkg::srcAPc;
                    word.aluSrcB = ctrlPkg::srcBBranch;
                    word.aluOp = ctrlPkg::aluAdd;
                    word.aluOutLoad = 1'b1;
                end else begin
                    word.loadAB = 1'b1;
                end
            end
            ctrlPkg::phExec: begin
                case (dec.cls)
                    ctrlPkg::clsArith: begin
                        if (step == 3'd0) begin
                            word.aluSrcA = ctrlPkg::srcARegA;
                            word.aluSrcB = dec.immOperand ? ctrlPkg::srcBImm : ctrlPkg::srcBRegB;
                            word.aluOp = dec.aluOp;
                            word.aluOutLoad = 1'b1;
                        end else begin
                            word.regWrite = 1'b1;
                            word.wrReg = dec.destIsRd ? ctrlPkg::wrRd : ctrlPkg::wrRt;
                            word.wdReg = ctrlPkg::wdAlu;
                        end
                    end
                    ctrlPkg::clsShift: begin
                        if (step == 3'd0) begin
                            word.shiftCtrl = ctrlPkg::shLoad;
                            word.shiftIn = dec.shiftByReg ? ctrlPkg::shInRegA : ctrlPkg::shInRegB;
                            word.shiftSrc = dec.shiftByReg ? ctrlPkg::shAmtReg : ctrlPkg::shAmtField;
                        end else if (step == 3'd1) begin
                            word.shiftCtrl = dec.shiftKind;
                        end else begin
                            word.regWrite = 1'b1;
                            word.wrReg = ctrlPkg::wrRd;
                            word.wdReg = ctrlPkg::wdShift;
                        end
                    end
                    ctrlPkg::clsStore, ctrlPkg::clsShiftMem: begin
                        // ALU keeps the address on its output during the memory steps
                        if (step <= 3'd3) begin
                            word.aluSrcA = ctrlPkg::srcARegA;
                            word.aluSrcB = dec.immOperand ? ctrlPkg::srcBImm : ctrlPkg::srcBRegB;
                            word.aluOp = dec.aluOp;
                        end
                        if (step >= 3'd1 && step <= 3'd3) begin
                            word.memRead = 1'b1;
                            word.iorD = ctrlPkg::iorAddr;
                        end
                        if (dec.cls == ctrlPkg::clsStore) begin
                            if (step == 3'd3) begin
                                word.memWrite = 1'b1;
                                word.storeCtrl = dec.storeSize;
                            end
                        end else if (step == 3'd4) begin
                            word.shiftCtrl = ctrlPkg::shLoad;
                            word.shiftIn = ctrlPkg::shInRegB;
                            word.shiftSrc = ctrlPkg::shAmtMem;
                        end else if (step == 3'd5) begin
                            word.shiftCtrl = dec.shiftKind;
                        end else if (step == 3'd6) begin
                            word.regWrite = 1'b1;
                            word.wrReg = dec.destIsRd ? ctrlPkg::wrRd : ctrlPkg::wrRt;
                            word.wdReg = ctrlPkg::wdShift;
                        end
                    end
                    default: begin
                        word = '0;
                    end
                endcase
            end
            default: begin
                // Overflow and illegal phases do nothing
                word = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wordQ <= '0;
        end else begin
            wordQ <= word;
        end
    end

    assign iorD = wordQ.iorD;
    assign wrReg = wordQ.wrReg;
    assign aluSrcA = wordQ.aluSrcA;
    assign aluSrcB = wordQ.aluSrcB;
    assign shiftIn = wordQ.shiftIn;
    assign shiftSrc = wordQ.shiftSrc;
    assign wdReg = wordQ.wdReg;
    assign pcWrite = wordQ.pcWrite;
    assign loadAB = wordQ.loadAB;
    assign aluOutLoad = wordQ.aluOutLoad;
    assign memWrite = wordQ.memWrite;
    assign memRead = wordQ.memRead;
    assign irWrite = wordQ.irWrite;
    assign aluOp = wordQ.aluOp;
    assign shiftCtrl = wordQ.shiftCtrl;
    assign storeCtrl = wordQ.storeCtrl;

    // Sequencer sits in overflow exactly while the arithmetic write would appear
    assign regWrite = wordQ.regWrite && (phase != ctrlPkg::phOverflow);

    irWriteWithPc: assert property (
        @(posedge clk) disable iff (reset)
        irWrite |-> pcWrite ##1 (!irWrite && !pcWrite)
    );

    noRegAndMemWrite: assert property (
        @(posedge clk) disable iff (reset)
        !(regWrite && memWrite)
    );

endmodule

/* controlUnit.sv */
// Multicycle control only; datapath, exception cause and PC source muxing live outside
`timescale 1ns/1ps

module controlUnit (
    input logic clk,
    input logic reset,
    input logic [ctrlPkg::opWidth-1:0] opcode,
    input logic [ctrlPkg::functWidth-1:0] funct,
    input logic overflow,
    output logic [1:0] iorD,
    output logic [1:0] wrReg,
    output logic [1:0] aluSrcA,
    output logic [1:0] aluSrcB,
    output logic [1:0] shiftIn,
    output logic [1:0] shiftSrc,
    output logic [2:0] wdReg,
    output logic pcWrite,
    output logic loadAB,
    output logic aluOutLoad,
    output logic memWrite,
    output logic memRead,
    output logic irWrite,
    output logic regWrite,
    output ctrlPkg::aluOpT aluOp,
    output ctrlPkg::shiftKindT shiftCtrl,
    output ctrlPkg::storeSizeT storeCtrl
);

    ctrlPkg::phaseT phase;
    logic [ctrlPkg::stepWidth-1:0] step;
    logic latchInstr;

    decodeIf decBus ();

    opDecoder decoder (
        .clk(clk),
        .reset(reset),
        .opcode(opcode),
        .funct(funct),
        .latchInstr(latchInstr),
        .dec(decBus.producer)
    );

    stepSequencer sequencer (
        .clk(clk),
        .reset(reset),
        .overflow(overflow),
        .dec(decBus.consumer),
        .phase(phase),
        .step(step),
        .latchInstr(latchInstr)
    );

    controlWordGen wordGen (
        .clk(clk),
        .reset(reset),
        .phase(phase),
        .step(step),
        .dec(decBus.consumer),
        .iorD(iorD),
        .wrReg(wrReg),
        .aluSrcA(aluSrcA),
        .aluSrcB(aluSrcB),
        .shiftIn(shiftIn),
        .shiftSrc(shiftSrc),
        .wdReg(wdReg),
        .pcWrite(pcWrite),
        .loadAB(loadAB),
        .aluOutLoad(aluOutLoad),
        .memWrite(memWrite),
        .memRead(memRead),
        .irWrite(irWrite),
        .regWrite(regWrite),
        .aluOp(aluOp),
        .shiftCtrl(shiftCtrl),
        .storeCtrl(storeCtrl)
    );

endmodule

/* controlChecker.sv */
// Holds at most 32 trace lines; each window runs from one irWrite pulse to the next
`timescale 1ns/1ps

module controlChecker (
    input logic clk,
    input logic reset,
    input logic irWrite,
    input logic pcWrite,
    input logic regWrite,
    input logic memWrite,
    input logic memRead,
    input logic loadAB,
    input logic aluOutLoad,
    input logic [1:0] iorD,
    input logic [1:0] aluSrcA,
    input logic [1:0] aluSrcB,
    input logic [1:0] shiftIn,
    input logic [1:0] shiftSrc,
    input logic [1:0] wrReg,
    input logic [2:0] wdReg,
    input ctrlPkg::aluOpT aluOp,
    input ctrlPkg::shiftKindT shiftCtrl,
    input ctrlPkg::storeSizeT storeCtrl,
    input int numLines,
    input int lineFunct [32],
    input int expSpacing [32],
    input int expRegW [32],
    input int expWrReg [32],
    input int expWdReg [32],
    input int expMemW [32],
    input int expStore [32],
    input int expShift [32],
    input int expMemReads [32],
    output int errorCount,
    output logic done
);

    logic started;
    logic windowOpen;
    logic fetchCycle;
    int line;
    int cycleCnt;
    int regCnt;
    int memWCnt;
    int memRCnt;
    int loadCnt;
    logic kindSeen;
    ctrlPkg::shiftKindT prevShift;

    task automatic compareValue(input string sig, input int expVal, input int actVal);
        if (expVal != actVal) begin
            $display("ERROR %0t %s expected %0d actual %0d", $time, sig, expVal, actVal);
            errorCount = errorCount + 1;
        end
    endtask

    // Amount select expected when the shifter loads
    function automatic int amountSelect(input int idx);
        if (expMemReads[idx] != 0) begin
            return int'(ctrlPkg::shAmtMem);
        end
        if (lineFunct[idx] == int'(ctrlPkg::functSllv) ||
                lineFunct[idx] == int'(ctrlPkg::functSrav)) begin
            return int'(ctrlPkg::shAmtReg);
        end
        return int'(ctrlPkg::shAmtField);
    endfunction

    task automatic closeWindow();
        int wantLoads;
        wantLoads = (expShift[line] != 0) ? 1 : 0;
        compareValue("spacing", expSpacing[line], cycleCnt + 1);
        compareValue("regWrite count", expRegW[line], regCnt);
        compareValue("memWrite count", expMemW[line], memWCnt);
        // Next fetch adds three reads to the window
        compareValue("memRead count", expMemReads[line] + 3, memRCnt);
        compareValue("shLoad count", wantLoads, loadCnt);
        if (wantLoads == 1 && !kindSeen) begin
            $display("Line %0d never showed its shift kind right after the load", line);
            errorCount = errorCount + 1;
        end
    endtask

    initial begin
        errorCount = 0;
        done = 1'b0;
    end

    always @(posedge clk) begin
        if (reset) begin
            started = 1'b0;
            windowOpen = 1'b0;
            line = 0;
            prevShift = ctrlPkg::shIdle;
        end else if (!done) begin
            if (!started) begin
                if (regWrite || memWrite || memRead || irWrite || pcWrite ||
                        wrReg != 2'd0 || wdReg != 3'd0 || shiftCtrl != ctrlPkg::shIdle) begin
                    // Stack pointer write comes first and alone
                    compareValue("regWrite", 1, int'(regWrite));
                    compareValue("wrReg", int'(ctrlPkg::wrSp), int'(wrReg));
                    compareValue("wdReg", int'(ctrlPkg::wdSpInit), int'(wdReg));
                    compareValue("memWrite", 0, int'(memWrite));
                    compareValue("memRead", 0, int'(memRead));
                    compareValue("irWrite", 0, int'(irWrite));
                    compareValue("pcWrite", 0, int'(pcWrite));
                    started = 1'b1;
                end
            end else if (irWrite) begin
                if (windowOpen) begin
                    closeWindow();
                    line = line + 1;
                    if (line >= numLines) begin
                        done = 1'b1;
                    end
                end
                windowOpen = 1'b1;
                cycleCnt = 0;
                regCnt = 0;
                memWCnt = 0;
                memRCnt = 0;
                loadCnt = 0;
                kindSeen = 1'b0;
            end else if (windowOpen) begin
                cycleCnt = cycleCnt + 1;
                // Last three cycles before the next irWrite are the fetch reads
                fetchCycle = (cycleCnt >= expSpacing[line] - 3);
                compareValue("loadAB", int'(cycleCnt == 2), int'(loadAB));
                if (cycleCnt == 1) begin
                    // Branch target add in the first decode step
                    compareValue("aluOutLoad", 1, int'(aluOutLoad));
                    compareValue("aluSrcA", int'(ctrlPkg::srcAPc), int'(aluSrcA));
                    compareValue("aluSrcB", int'(ctrlPkg::srcBBranch), int'(aluSrcB));
                    compareValue("aluOp", int'(ctrlPkg::aluAdd), int'(aluOp));
                end
                if (fetchCycle) begin
                    compareValue("memRead", 1, int'(memRead));
                    compareValue("iorD", int'(ctrlPkg::iorPc), int'(iorD));
                    compareValue("aluSrcA", int'(ctrlPkg::srcAPc), int'(aluSrcA));
                    compareValue("aluSrcB", int'(ctrlPkg::srcBFour), int'(aluSrcB));
                    compareValue("aluOp", int'(ctrlPkg::aluAdd), int'(aluOp));
                end else if (memRead) begin
                    compareValue("iorD", int'(ctrlPkg::iorAddr), int'(iorD));
                end
                if (regWrite) begin
                    regCnt = regCnt + 1;
                    compareValue("wrReg", expWrReg[line], int'(wrReg));
                    compareValue("wdReg", expWdReg[line], int'(wdReg));
                end
                if (memWrite) begin
                    memWCnt = memWCnt + 1;
                    compareValue("storeCtrl", expStore[line], int'(storeCtrl));
                end
                if (memRead) begin
                    memRCnt = memRCnt + 1;
                end
                if (prevShift == ctrlPkg::shLoad) begin
                    compareValue("shiftCtrl", expShift[line], int'(shiftCtrl));
                    kindSeen = 1'b1;
                end
                if (shiftCtrl == ctrlPkg::shLoad) begin
                    loadCnt = loadCnt + 1;
                    compareValue("shiftSrc", amountSelect(line), int'(shiftSrc));
                end else begin
                    // Shifter muxes rest at zero outside a load
                    compareValue("shiftIn", 0, int'(shiftIn));
                    compareValue("shiftSrc", 0, int'(shiftSrc));
                end
            end
            prevShift = shiftCtrl;
        end
    end

endmodule

/* controlUnitTb.sv */
// Reads controlTrace.txt from the working directory; wildcard opcodes get random illegal codes
`timescale 1ns/1ps

module controlUnitTb;

    logic clk;
    logic reset;
    logic [5:0] opcode;
    logic [5:0] funct;
    logic overflow;

    logic [1:0] iorD;
    logic [1:0] wrReg;
    logic [1:0] aluSrcA;
    logic [1:0] aluSrcB;
    logic [1:0] shiftIn;
    logic [1:0] shiftSrc;
    logic [2:0] wdReg;
    logic pcWrite;
    logic loadAB;
    logic aluOutLoad;
    logic memWrite;
    logic memRead;
    logic irWrite;
    logic regWrite;
    ctrlPkg::aluOpT aluOp;
    ctrlPkg::shiftKindT shiftCtrl;
    ctrlPkg::storeSizeT storeCtrl;

    int opArr [32];
    int functArr [32];
    int ovfArr [32];
    int expSpacing [32];
    int expRegW [32];
    int expWrReg [32];
    int expWdReg [32];
    int expMemW [32];
    int expStore [32];
    int expShift [32];
    int expMemReads [32];
    int numLines;
    int driveIdx;
    int cycleCount;
    int cycleLimit;
    int tbErrors;
    int checkErrors;
    logic checkDone;
    integer seed;

    controlUnit DUT (
        .clk(clk), .reset(reset), .opcode(opcode), .funct(funct), .overflow(overflow),
        .iorD(iorD), .wrReg(wrReg), .aluSrcA(aluSrcA), .aluSrcB(aluSrcB),
        .shiftIn(shiftIn), .shiftSrc(shiftSrc), .wdReg(wdReg), .pcWrite(pcWrite),
        .loadAB(loadAB), .aluOutLoad(aluOutLoad), .memWrite(memWrite), .memRead(memRead),
        .irWrite(irWrite), .regWrite(regWrite), .aluOp(aluOp), .shiftCtrl(shiftCtrl),
        .storeCtrl(storeCtrl)
    );

    controlChecker outputCheck (
        .clk(clk), .reset(reset), .irWrite(irWrite), .pcWrite(pcWrite),
        .regWrite(regWrite), .memWrite(memWrite), .memRead(memRead), .loadAB(loadAB),
        .aluOutLoad(aluOutLoad), .iorD(iorD), .aluSrcA(aluSrcA), .aluSrcB(aluSrcB),
        .shiftIn(shiftIn), .shiftSrc(shiftSrc), .wrReg(wrReg), .wdReg(wdReg),
        .aluOp(aluOp), .shiftCtrl(shiftCtrl), .storeCtrl(storeCtrl), .numLines(numLines),
        .lineFunct(functArr), .expSpacing(expSpacing), .expRegW(expRegW),
        .expWrReg(expWrReg), .expWdReg(expWdReg), .expMemW(expMemW), .expStore(expStore),
        .expShift(expShift), .expMemReads(expMemReads), .errorCount(checkErrors),
        .done(checkDone)
    );

    always #2 clk = ~clk;

    function automatic logic isKnownOpcode(input logic [5:0] op);
        return op == ctrlPkg::opTypeR || op == ctrlPkg::opAddi || op == ctrlPkg::opSram ||
            op == ctrlPkg::opSb || op == ctrlPkg::opSh || op == ctrlPkg::opSw;
    endfunction

    task automatic readTrace();
        int fd;
        int n;
        int opVal;
        string text;
        string tok;
        logic [31:0] cand;
        fd = $fopen("controlTrace.txt", "r");
        if (fd == 0) begin
            $display("Could not open controlTrace.txt");
            tbErrors = tbErrors + 1;
            return;
        end
        while (!$feof(fd) && numLines < 32) begin
            text = "";
            void'($fgets(text, fd));
            if (text.len() < 2 || text[0] == "#") begin
                continue;
            end
            n = $sscanf(text, "%s %h %d %d %d %d %d %d %d %d %d", tok, functArr[numLines],
                ovfArr[numLines], expSpacing[numLines], expRegW[numLines],
                expWrReg[numLines], expWdReg[numLines], expMemW[numLines],
                expStore[numLines], expShift[numLines], expMemReads[numLines]);
            if (n != 11) begin
                $display("Malformed trace line: %s", text);
                tbErrors = tbErrors + 1;
                continue;
            end
            if (tok == "*") begin
                do begin
                    cand = $random(seed);
                end while (isKnownOpcode(cand[5:0]));
                opArr[numLines] = int'(cand[5:0]);
            end else begin
                void'($sscanf(tok, "%h", opVal));
                opArr[numLines] = opVal;
            end
            numLines = numLines + 1;
        end
        $fclose(fd);
    endtask

    // Next instruction goes out as the current one is written to IR
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (!reset && irWrite) begin
            if (driveIdx < numLines) begin
                opcode <= opArr[driveIdx][5:0];
                funct <= functArr[driveIdx][5:0];
                overflow <= ovfArr[driveIdx][0];
            end
            driveIdx <= driveIdx + 1;
        end
    end

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        opcode = 6'd0;
        funct = 6'd0;
        overflow = 1'b0;
        numLines = 0;
        driveIdx = 0;
        cycleCount = 0;
        tbErrors = 0;
        seed = 32'h8365;
        readTrace();
        cycleLimit = 50;
        for (int i = 0; i < numLines; i++) begin
            cycleLimit = cycleLimit + expSpacing[i];
        end
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        if (numLines > 0) begin
            wait (checkDone || cycleCount >= cycleLimit);
            if (!checkDone) begin
                $display("Timeout after %0d cycles before all trace lines finished", cycleCount);
                tbErrors = tbErrors + 1;
            end
        end else begin
            $display("No usable trace lines were read");
            tbErrors = tbErrors + 1;
        end
        @(posedge clk);
        $display("Errors: %0d checker, %0d testbench", checkErrors, tbErrors);
        if (checkErrors == 0 && tbErrors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* build.f */
ctrlPkg.sv
decodeIf.sv
opDecoder.sv
stepSequencer.sv
controlWordGen.sv
controlUnit.sv
controlChecker.sv
controlUnitTb.sv

/* run.sh */
#!/bin/sh
# Builds with Verilator and runs the testbench from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f \
    --top-module controlUnitTb -o controlUnitSim > build.log 2>&1 \
    || { cat build.log; echo "build error"; exit 1; }

./obj_dir/controlUnitSim > sim.log 2>&1
cat sim.log
grep -q "sim failed" sim.log && exit 1 || grep -q "sim passed" sim.log || exit 1
exit 0

/* controlTrace.txt */
# opcode(hex, * = random illegal) funct(hex) overflow spacing regWrite wrReg wdReg
# memWrite storeCtrl shiftKind execMemReads
00 20 0 8 1 1 0 0 0 0 0
00 22 0 8 1 1 0 0 0 0 0
08 00 0 8 1 0 0 0 0 0 0
00 20 1 9 0 0 0 0 0 0 0
08 00 1 9 0 0 0 0 0 0 0
00 00 0 9 1 1 5 0 0 2 0
00 04 0 9 1 1 5 0 0 2 0
00 03 0 9 1 1 5 0 0 4 0
00 07 0 9 1 1 5 0 0 4 0
00 02 0 9 1 1 5 0 0 3 0
00 02 1 9 1 1 5 0 0 3 0
28 00 0 11 0 0 0 1 2 0 3
29 00 0 11 0 0 0 1 1 0 3
2b 00 0 11 0 0 0 1 0 0 3
01 00 0 13 1 0 5 0 0 4 3
00 3f 0 7 0 0 0 0 0 0 0
* 00 0 7 0 0 0 0 0 0 0
* 15 0 7 0 0 0 0 0 0 0
00 22 1 9 0 0 0 0 0 0 0
2b 00 1 11 0 0 0 1 0 0 3
* 20 1 7 0 0 0 0 0 0 0
00 20 0 8 1 1 0 0 0 0 0
